// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_exec
FILELIST  ?= verilog.f
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== alu.sv ====
`timescale 1ns/1ps

module alu
  import exec_pkg::*;
(
  input  word_t       op_a,
  input  word_t       op_b,
  input  logic [15:0] imm,
  input  opcode_e     opcode,
  input  cond_e       cond,
  input  shift_e      shift_ctrl,
  input  logic [4:0]  amount,
  input  logic        sbit,
  input  flags_t      flags_in,
  output word_t       result,
  output flags_t      flags_out,
  output logic        rd_we,
  output logic        flags_we
);

  logic        cond_met;
  word_t       b_shifted;
  opcode_e     eff_op;
  logic [32:0] sum_ext;
  logic [32:0] diff_ext;
  logic        add_ovf;
  logic        sub_ovf;
  logic        is_alu_op;

  cond_check cond_check_i (
    .cond  (cond),
    .flags (flags_in),
    .met   (cond_met)
  );

  operand_shifter operand_shifter_i (
    .operand    (op_b),
    .shift_ctrl (shift_ctrl),
    .amount     (amount),
    .shifted    (b_shifted)
  );

  // failed condition turns the instruction into a nop
  assign eff_op = cond_met ? opcode : OP_NOP;

  // extra top bit holds carry or borrow
  assign sum_ext  = {1'b0, op_a} + {1'b0, b_shifted};
  assign diff_ext = {1'b0, op_a} - {1'b0, b_shifted};
  assign add_ovf  = (op_a[31] == b_shifted[31]) && (sum_ext[31] != op_a[31]);
  assign sub_ovf  = (op_a[31] != b_shifted[31]) && (diff_ext[31] != op_a[31]);

  assign is_alu_op = eff_op inside {OP_ADD, OP_SUB, OP_MUL, OP_ORR,
                                    OP_AND, OP_EOR, OP_MOVI, OP_MOV};

  always_comb
  begin
    case (eff_op)
      OP_ADD:  result = sum_ext[31:0];
      OP_SUB:  result = diff_ext[31:0];
      // low half of the product only
      OP_MUL:  result = op_a * b_shifted;
      OP_ORR:  result = op_a | b_shifted;
      OP_AND:  result = op_a & b_shifted;
      OP_EOR:  result = op_a ^ b_shifted;
      OP_MOVI: result = {16'h0000, imm};
      OP_MOV:  result = b_shifted;
      OP_CMP:  result = diff_ext[31:0];
      OP_NOP:  result = '0;
      default: result = '0;
    endcase
  end

  always_comb
  begin
    flags_out = flags_in;
    if (is_alu_op || (eff_op == OP_CMP))
    begin
      flags_out[FLAG_N] = result[31];
      flags_out[FLAG_Z] = (result == '0);
    end
    case (eff_op)
      OP_ADD:
      begin
        flags_out[FLAG_C] = sum_ext[32];
        flags_out[FLAG_V] = add_ovf;
      end
      // carry set means no borrow
      OP_SUB, OP_CMP:
      begin
        flags_out[FLAG_C] = !diff_ext[32];
        flags_out[FLAG_V] = sub_ovf;
      end
      default:
      begin
        flags_out[FLAG_C] = flags_in[FLAG_C];
        flags_out[FLAG_V] = flags_in[FLAG_V];
      end
    endcase
  end

  assign rd_we    = is_alu_op;
  assign flags_we = (is_alu_op && sbit) || (eff_op == OP_CMP);

endmodule

// ==== apb_exec_if.sv ====
`timescale 1ns/1ps

module apb_exec_if
  import exec_pkg::*;
#(
  parameter int ADDR_W = 8
)
(
  input  logic              clk,
  input  logic              arst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  word_t             pwdata,
  output word_t             prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              issue,
  output word_t             instr,
  output logic              host_reg_we,
  output reg_idx_t          host_reg_idx,
  output word_t             host_wdata,
  output logic              host_flags_we,
  input  word_t             host_rdata,
  input  flags_t            flags
);

  localparam logic [ADDR_W-1:0] A_INSTR    = ADDR_W'(ADDR_INSTR);
  localparam logic [ADDR_W-1:0] A_FLAGS    = ADDR_W'(ADDR_FLAGS);
  localparam logic [ADDR_W-1:0] A_REG_BASE = ADDR_W'(ADDR_REG_BASE);
  localparam logic [ADDR_W-1:0] A_REG_END  = ADDR_W'(ADDR_REG_BASE + ADDR_REG_SPAN);

  logic              access;
  logic              aligned;
  logic              hit_instr;
  logic              hit_flags;
  logic              hit_reg;
  logic              addr_err;
  logic              wr_ok;
  logic              rd_ok;
  logic [ADDR_W-1:0] reg_off;

  assign access  = psel && penable;
  assign aligned = (paddr[1:0] == 2'b00);

  // address decode
  assign hit_instr = (paddr == A_INSTR);
  assign hit_flags = (paddr == A_FLAGS);
  assign hit_reg   = (paddr >= A_REG_BASE) && (paddr < A_REG_END);
  assign reg_off   = paddr - A_REG_BASE;

  // instruction slot is write only
  assign addr_err = !aligned ||
                    !((hit_instr && pwrite) || hit_flags || hit_reg);

  assign wr_ok = access && pwrite && !addr_err;
  assign rd_ok = access && !pwrite && !addr_err;

  // zero wait states
  assign pready  = access;
  assign pslverr = access && addr_err;

  assign issue         = wr_ok && hit_instr;
  assign host_reg_we   = wr_ok && hit_reg;
  assign host_flags_we = wr_ok && hit_flags;

  assign instr        = pwdata;
  assign host_wdata   = pwdata;
  assign host_reg_idx = reg_off[5:2];

  always_comb
  begin
    prdata = '0;
    if (rd_ok && hit_flags)
    begin
      prdata = {28'h0000000, flags};
    end
    else if (rd_ok && hit_reg)
    begin
      prdata = host_rdata;
    end
  end

  a_penable_needs_psel: assert property (
    @(posedge clk) disable iff (!arst_n) penable |-> psel
  ) else $error("penable without psel");

  // address held from setup into access
  a_paddr_stable: assert property (
    @(posedge clk) disable iff (!arst_n) (psel && !penable) |=> $stable(paddr)
  ) else $error("paddr changed between setup and access");

endmodule

// ==== cond_check.sv ====
`timescale 1ns/1ps

module cond_check
  import exec_pkg::*;
(
  input  cond_e  cond,
  input  flags_t flags,
  output logic   met
);

  logic n_eq_v;

  // signed compare results share this term
  assign n_eq_v = (flags[FLAG_N] == flags[FLAG_V]);

  always_comb
  begin
    case (cond)
      AL: met = 1'b1;
      EQ: met = flags[FLAG_Z];
      GT: met = !flags[FLAG_Z] && n_eq_v;
      LT: met = !flags[FLAG_Z] && !n_eq_v;
      GE: met = n_eq_v;
      LE: met = !n_eq_v;
      // unsigned higher needs carry and nonzero
      HI: met = !flags[FLAG_Z] && flags[FLAG_C];
      LO: met = !flags[FLAG_C];
      HS: met = flags[FLAG_C];
      // unused codes behave as always
      default: met = 1'b1;
    endcase
  end

endmodule

// ==== exec_core.sv ====
`timescale 1ns/1ps

module exec_core
  import exec_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     issue,
  input  word_t    instr,
  input  logic     host_reg_we,
  input  reg_idx_t host_reg_idx,
  input  word_t    host_wdata,
  input  logic     host_flags_we,
  output word_t    host_rdata,
  output flags_t   flags
);

  cond_e       f_cond;
  opcode_e     f_opcode;
  logic        f_sbit;
  shift_e      f_shift;
  reg_idx_t    f_rd;
  reg_idx_t    f_rn;
  reg_idx_t    f_rm;
  logic [4:0]  f_amount;
  logic [15:0] f_imm;

  word_t       rn_data;
  word_t       rm_data;
  word_t       alu_result;
  flags_t      alu_flags;
  logic        alu_rd_we;
  logic        alu_flags_we;
  logic        inst_rd_we;
  logic        inst_flags_we;

  logic        rf_we;
  reg_idx_t    rf_w_idx;
  word_t       rf_w_data;

  // field slicing
  assign f_cond   = cond_e'(instr[INSTR_COND_MSB:INSTR_COND_LSB]);
  assign f_opcode = opcode_e'(instr[INSTR_OP_MSB:INSTR_OP_LSB]);
  assign f_sbit   = instr[INSTR_SBIT];
  assign f_shift  = shift_e'(instr[INSTR_SHIFT_MSB:INSTR_SHIFT_LSB]);
  assign f_rd     = instr[INSTR_RD_MSB:INSTR_RD_LSB];
  assign f_rn     = instr[INSTR_RN_MSB:INSTR_RN_LSB];
  assign f_rm     = instr[INSTR_RM_MSB:INSTR_RM_LSB];
  assign f_amount = instr[INSTR_AMT_MSB:INSTR_AMT_LSB];
  assign f_imm    = instr[INSTR_IMM_MSB:INSTR_IMM_LSB];

  alu alu_i (
    .op_a       (rn_data),
    .op_b       (rm_data),
    .imm        (f_imm),
    .opcode     (f_opcode),
    .cond       (f_cond),
    .shift_ctrl (f_shift),
    .amount     (f_amount),
    .sbit       (f_sbit),
    .flags_in   (flags),
    .result     (alu_result),
    .flags_out  (alu_flags),
    .rd_we      (alu_rd_we),
    .flags_we   (alu_flags_we)
  );

  // instruction effects only with an issue strobe
  assign inst_rd_we    = issue && alu_rd_we;
  assign inst_flags_we = issue && alu_flags_we;

  assign rf_we     = inst_rd_we || host_reg_we;
  assign rf_w_idx  = inst_rd_we ? f_rd : host_reg_idx;
  assign rf_w_data = inst_rd_we ? alu_result : host_wdata;

  reg_file reg_file_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .ra_idx  (f_rn),
    .rb_idx  (f_rm),
    .rh_idx  (host_reg_idx),
    .ra_data (rn_data),
    .rb_data (rm_data),
    .rh_data (host_rdata),
    .we      (rf_we),
    .w_idx   (rf_w_idx),
    .w_data  (rf_w_data)
  );

  // nzcv register
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      flags <= '0;
    end
    else if (inst_flags_we)
    begin
      flags <= alu_flags;
    end
    else if (host_flags_we)
    begin
      flags <= host_wdata[3:0];
    end
  end

  // apb decode keeps the two write sources apart
  a_no_write_clash: assert property (
    @(posedge clk) disable iff (!arst_n) !(issue && host_reg_we)
  ) else $error("issue and host register write in the same cycle");

endmodule

// ==== exec_pkg.sv ====
package exec_pkg;

  // data and register types
  typedef logic [31:0] word_t;
  typedef logic [3:0]  flags_t;
  typedef logic [3:0]  reg_idx_t;

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_MUL  = 4'd2,
    OP_ORR  = 4'd3,
    OP_AND  = 4'd4,
    OP_EOR  = 4'd5,
    OP_MOVI = 4'd6,
    OP_MOV  = 4'd7,
    OP_CMP  = 4'd8,
    OP_NOP  = 4'd15
  } opcode_e;

  // codes 9 to 15 act as AL
  typedef enum logic [3:0] {
    AL = 4'd0,
    EQ = 4'd1,
    GT = 4'd2,
    LT = 4'd3,
    GE = 4'd4,
    LE = 4'd5,
    HI = 4'd6,
    LO = 4'd7,
    HS = 4'd8
  } cond_e;

  typedef enum logic [2:0] {
    SH_NONE = 3'd0,
    SH_LSR  = 3'd1,
    SH_LSL  = 3'd2,
    SH_ROR  = 3'd3
  } shift_e;

  // bit positions inside flags_t
  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  // instruction word fields
  localparam int INSTR_COND_MSB   = 31;
  localparam int INSTR_COND_LSB   = 28;
  localparam int INSTR_OP_MSB     = 27;
  localparam int INSTR_OP_LSB     = 24;
  localparam int INSTR_SBIT       = 23;
  localparam int INSTR_SHIFT_MSB  = 22;
  localparam int INSTR_SHIFT_LSB  = 20;
  localparam int INSTR_RD_MSB     = 19;
  localparam int INSTR_RD_LSB     = 16;
  localparam int INSTR_RN_MSB     = 15;
  localparam int INSTR_RN_LSB     = 12;
  localparam int INSTR_RM_MSB     = 11;
  localparam int INSTR_RM_LSB     = 8;
  localparam int INSTR_AMT_MSB    = 7;
  localparam int INSTR_AMT_LSB    = 3;
  localparam int INSTR_IMM_MSB    = 15;
  localparam int INSTR_IMM_LSB    = 0;

  // APB byte addresses
  localparam int unsigned ADDR_INSTR    = 32'h00;
  localparam int unsigned ADDR_FLAGS    = 32'h04;
  localparam int unsigned ADDR_REG_BASE = 32'h40;
  localparam int unsigned ADDR_REG_SPAN = 32'h40;

endpackage

// ==== exec_top.sv ====
`timescale 1ns/1ps

module exec_top
  import exec_pkg::*;
#(
  parameter int ADDR_W = 8
)
(
  input  logic              clk,
  input  logic              arst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  word_t             pwdata,
  output word_t             prdata,
  output logic              pready,
  output logic              pslverr
);

  logic     issue;
  word_t    instr;
  logic     host_reg_we;
  reg_idx_t host_reg_idx;
  word_t    host_wdata;
  logic     host_flags_we;
  word_t    host_rdata;
  flags_t   flags;

  apb_exec_if #(
    .ADDR_W (ADDR_W)
  ) apb_exec_if_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .issue         (issue),
    .instr         (instr),
    .host_reg_we   (host_reg_we),
    .host_reg_idx  (host_reg_idx),
    .host_wdata    (host_wdata),
    .host_flags_we (host_flags_we),
    .host_rdata    (host_rdata),
    .flags         (flags)
  );

  exec_core exec_core_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .issue         (issue),
    .instr         (instr),
    .host_reg_we   (host_reg_we),
    .host_reg_idx  (host_reg_idx),
    .host_wdata    (host_wdata),
    .host_flags_we (host_flags_we),
    .host_rdata    (host_rdata),
    .flags         (flags)
  );

endmodule

// ==== exec_trace.txt ====
# exec_top APB trace, one transfer per line, values in hex
# W addr data err   write, err is the expected pslverr
# R addr data err   read, data is checked only when err is 0
# F nzcv            read of the flag register
# T name            start of a named test
T reset_zero
R 40 00000000 0
R 44 00000000 0
R 48 00000000 0
R 4C 00000000 0
R 50 00000000 0
R 54 00000000 0
R 58 00000000 0
R 5C 00000000 0
R 60 00000000 0
R 64 00000000 0
R 68 00000000 0
R 6C 00000000 0
R 70 00000000 0
R 74 00000000 0
R 78 00000000 0
R 7C 00000000 0
F 0
T preload
W 40 A5A5A5A5 0
R 40 A5A5A5A5 0
W 44 00000005 0
R 44 00000005 0
W 48 00000003 0
R 48 00000003 0
W 4C 7FFFFFFF 0
R 4C 7FFFFFFF 0
W 50 80000001 0
R 50 80000001 0
W 54 F0F0F0F0 0
R 54 F0F0F0F0 0
W 58 0FF00FF0 0
R 58 0FF00FF0 0
W 5C 12345678 0
R 5C 12345678 0
W 60 00000008 0
R 60 00000008 0
W 64 99999999 0
R 64 99999999 0
W 68 AAAAAAAA 0
R 68 AAAAAAAA 0
W 6C BBBBBBBB 0
R 6C BBBBBBBB 0
W 70 CCCCCCCC 0
R 70 CCCCCCCC 0
W 74 DDDDDDDD 0
R 74 DDDDDDDD 0
W 78 EEEEEEEE 0
R 78 EEEEEEEE 0
W 7C FFFFFFFF 0
R 7C FFFFFFFF 0
W 04 0000000F 0
F F
W 04 00000000 0
F 0
T arith_logic
W 00 00081200 0
R 60 00000008 0
W 00 01091200 0
R 64 00000002 0
W 00 020A1200 0
R 68 0000000F 0
W 00 030B5600 0
R 6C FFF0FFF0 0
W 00 040C5600 0
R 70 00F000F0 0
W 00 050D5600 0
R 74 FF00FF00 0
W 00 060EBEEF 0
R 78 0000BEEF 0
W 00 070F0700 0
R 7C 12345678 0
F 0
T flags
W 00 00884400 0
R 60 00000002 0
F 3
W 00 01891100 0
R 64 00000000 0
F 6
W 00 080A1200 0
R 68 0000000F 0
F 2
W 04 00000003 0
W 00 038B4200 0
R 6C 80000003 0
F B
T shifts
W 00 071C0700 0
R 70 12345678 0
W 00 071C0708 0
R 70 091A2B3C 0
W 00 071C04F8 0
R 70 00000001 0
W 00 072D04F8 0
R 74 80000000 0
W 00 002D1208 0
R 74 0000000B 0
W 00 073E0408 0
R 78 C0000000 0
W 00 073E04F8 0
R 78 00000003 0
W 00 003E1208 0
R 78 80000006 0
W 00 002F1700 0
R 7C 1234567D 0
W 00 001F14F8 0
R 7C 00000006 0
T conditions
W 04 00000004 0
W 00 1608A001 0
W 00 2609A002 0
W 00 360AA003 0
W 00 460BA004 0
W 00 560CA005 0
W 00 660DA006 0
W 00 760EA007 0
W 00 860FA008 0
W 00 28001200 0
F 4
R 60 0000A001 0
R 64 00000000 0
R 68 0000000F 0
R 6C 0000A004 0
R 70 00000001 0
R 74 0000000B 0
R 78 0000A007 0
R 7C 00000006 0
W 04 00000002 0
W 00 1608B001 0
W 00 2609B002 0
W 00 660DB006 0
W 00 760EB007 0
W 00 860FB008 0
R 60 0000A001 0
R 64 0000B002 0
R 74 0000B006 0
R 78 0000A007 0
R 7C 0000B008 0
W 04 00000008 0
W 00 360AC003 0
W 00 460BC004 0
W 00 560CC005 0
W 00 41881100 0
R 60 0000A001 0
R 68 0000C003 0
R 6C 0000A004 0
R 70 0000C005 0
F 8
T reserved_nop
W 00 09881200 0
W 00 0E8F1200 0
W 00 0F881200 0
R 60 0000A001 0
R 7C 0000B008 0
F 8
T errors
R 00 00000000 1
W 20 12345678 1
R 20 00000000 1
W 80 12345678 1
W 41 00000000 1
R 42 00000000 1
W 06 0000000F 1
W 7E 00000000 1
R 40 A5A5A5A5 0
R 7C 0000B008 0
F 8

// ==== operand_shifter.sv ====
`timescale 1ns/1ps

module operand_shifter
  import exec_pkg::*;
(
  input  word_t      operand,
  input  shift_e     shift_ctrl,
  input  logic [4:0] amount,
  output word_t      shifted
);

  logic [63:0] rot_wide;

  // rotate via a doubled copy shifted right
  assign rot_wide = {operand, operand} >> amount;

  always_comb
  begin
    case (shift_ctrl)
      SH_NONE:
      begin
        shifted = operand;
      end
      SH_LSR:
      begin
        shifted = operand >> amount;
      end
      SH_LSL:
      begin
        shifted = operand << amount;
      end
      SH_ROR:
      begin
        shifted = rot_wide[31:0];
      end
      // codes 4 to 7 pass straight through
      default:
      begin
        shifted = operand;
      end
    endcase
  end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file
  import exec_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  reg_idx_t ra_idx,
  input  reg_idx_t rb_idx,
  input  reg_idx_t rh_idx,
  output word_t    ra_data,
  output word_t    rb_data,
  output word_t    rh_data,
  input  logic     we,
  input  reg_idx_t w_idx,
  input  word_t    w_data
);

  word_t regs [16];

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < 16; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (we)
    begin
      regs[w_idx] <= w_data;
    end
  end

  // operand ports for the alu
  assign ra_data = regs[ra_idx];
  assign rb_data = regs[rb_idx];

  // host readback port
  assign rh_data = regs[rh_idx];

endmodule

// ==== tb_exec.sv ====
`timescale 1ns/1ps

module tb_exec
  import exec_pkg::*;
();

  localparam int ADDR_W        = 8;
  localparam int CLK_PERIOD    = 8;
  localparam int DRIVE_DELAY   = 1;
  localparam int RESET_CYCLES  = 10;
  // setup, access and one idle cycle, with slack
  localparam int CYCLES_PER_OP = 4;

  typedef logic [8*32-1:0] name_t;

  logic              clk;
  logic              arst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [ADDR_W-1:0] paddr;
  word_t             pwdata;
  word_t             prdata;
  logic              pready;
  logic              pslverr;

  // parsed trace entries, one slot per line
  logic [7:0] kinds [$];
  word_t      addrs [$];
  word_t      datas [$];
  logic       errs  [$];
  name_t      names [$];

  int    trace_len;
  int    error_count;
  name_t test_name;
  logic  trace_loaded;

  exec_top #(
    .ADDR_W (ADDR_W)
  ) dut_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (act !== exp)
    begin
      error_count++;
      $display("Mismatch in %0s: %0s expected %h actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flags(input flags_t exp, input flags_t act);
    if (act !== exp)
    begin
      error_count++;
      $display("Mismatch in %0s: nzcv expected %b actual %b", test_name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_err(input string what, input logic exp, input logic act);
    if (act !== exp)
    begin
      error_count++;
      $display("Mismatch in %0s: %0s expected %b actual %b", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic parse_line(input string line);
    logic [7:0] kind;
    word_t      a;
    word_t      d;
    word_t      e;
    name_t      nm;
    int         n;
    int         want;
    kind = line[0];
    a = '0;
    d = '0;
    e = '0;
    nm = '0;
    n = 0;
    want = 0;
    case (kind)
      "W", "R":
      begin
        want = 4;
        n = $sscanf(line, "%c %h %h %h", kind, a, d, e);
      end
      "F":
      begin
        want = 2;
        n = $sscanf(line, "%c %h", kind, d);
      end
      "T":
      begin
        want = 2;
        n = $sscanf(line, "%c %s", kind, nm);
      end
      default:
      begin
        $display("Error: unknown entry kind in trace line: %s", line);
        abort_run();
      end
    endcase
    if (n != want)
    begin
      $display("Error: malformed trace line: %s", line);
      abort_run();
    end
    kinds.push_back(kind);
    addrs.push_back(a);
    datas.push_back(d);
    errs.push_back(e[0]);
    names.push_back(nm);
    if (kind != "T")
    begin
      trace_len++;
    end
  endtask

  task automatic load_trace();
    int    fd;
    string line;
    fd = $fopen("exec_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Error: cannot open the trace file exec_trace.txt");
      abort_run();
    end
    while ($fgets(line, fd) != 0)
    begin
      // skip comments and blank lines
      if (line.len() > 1 && line[0] != "#")
      begin
        parse_line(line);
      end
    end
    $fclose(fd);
    if (trace_len == 0)
    begin
      $display("Error: the trace holds no transfers");
      abort_run();
    end
  endtask

  task automatic apply_reset();
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    arst_n = 1'b1;
  endtask

  // bus idle, so no response may be showing
  task automatic check_idle();
    check_err("pready while idle", 1'b0, pready);
    check_err("pslverr while idle", 1'b0, pslverr);
  endtask

  // zero wait states, pready must be up in the first access cycle
  task automatic finish_access(output word_t rdata, output logic err);
    @(negedge clk);
    check_err("pready", 1'b1, pready);
    rdata = prdata;
    err = pslverr;
    @(posedge clk);
    #(DRIVE_DELAY);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input word_t data,
                           output logic err);
    word_t unused_rdata;
    @(posedge clk);
    #(DRIVE_DELAY);
    check_idle();
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge clk);
    #(DRIVE_DELAY);
    penable = 1'b1;
    finish_access(unused_rdata, err);
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, output word_t data,
                          output logic err);
    @(posedge clk);
    #(DRIVE_DELAY);
    check_idle();
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(posedge clk);
    #(DRIVE_DELAY);
    penable = 1'b1;
    finish_access(data, err);
  endtask

  task automatic run_entry(input int i);
    word_t rdata;
    logic  err;
    case (kinds[i])
      "T":
      begin
        test_name = names[i];
      end
      "W":
      begin
        apb_write(addrs[i][ADDR_W-1:0], datas[i], err);
        check_err("pslverr", errs[i], err);
      end
      "R":
      begin
        apb_read(addrs[i][ADDR_W-1:0], rdata, err);
        check_err("pslverr", errs[i], err);
        // read data is undefined on an error response
        if (!errs[i])
        begin
          check_word("prdata", datas[i], rdata);
        end
      end
      default:
      begin
        apb_read(ADDR_W'(ADDR_FLAGS), rdata, err);
        check_err("pslverr", 1'b0, err);
        check_flags(datas[i][3:0], rdata[3:0]);
      end
    endcase
  endtask

  initial
  begin
    int i;
    clk = 1'b0;
    arst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    trace_len = 0;
    error_count = 0;
    trace_loaded = 1'b0;
    test_name = "reset";
    load_trace();
    trace_loaded = 1'b1;
    apply_reset();
    for (i = 0; i < kinds.size(); i++)
    begin
      run_entry(i);
    end
    @(posedge clk);
    if (error_count == 0)
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
    else
    begin
      abort_run();
    end
  end

  // watchdog sized from the trace length
  initial
  begin
    wait (trace_loaded === 1'b1);
    #(CLK_PERIOD * (trace_len * CYCLES_PER_OP + RESET_CYCLES + 4));
    $display("Error: the run hung, the trace did not finish in time");
    abort_run();
  end

endmodule

// ==== verilog.f ====
exec_pkg.sv
cond_check.sv
operand_shifter.sv
alu.sv
reg_file.sv
exec_core.sv
apb_exec_if.sv
exec_top.sv
tb_exec.sv
